/* run.sh */
#!/bin/sh
# build the BC1 decoder testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module bc1_decoder_tb -f vlog.f &&
  ./obj_dir/Vbc1_decoder_tb +verilator+error+limit+100 | tee /dev/stderr |
  grep -q "^Test OK$" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

/* source/bc1_block_intake.sv */
`timescale 1ns/1ns
`default_nettype none

module bc1_block_intake
  import bc1_pkg::*;
(
  input  logic               clk,
  input  logic               rstn,
  input  logic               in_req,
  output logic               in_ack,
  input  logic [BLOCK_W-1:0] in_block,
  output logic               blk_valid,
  input  logic               blk_ready,
  output logic [BLOCK_W-1:0] blk_data
);

  logic               full;
  logic [BLOCK_W-1:0] block_q;
  logic               capture;

  // new request, room in the buffer, last handshake closed
  assign capture = in_req && !full && !in_ack;

  // four-phase ack and buffer occupancy
  always_ff @(posedge clk) begin
    if (!rstn) begin
      in_ack <= 1'b0;
      full   <= 1'b0;
    end else begin
      if (capture) begin
        in_ack <= 1'b1;
        full   <= 1'b1;
      end else begin
        // return to zero once the sender drops req
        if (in_ack && !in_req) begin
          in_ack <= 1'b0;
        end
        if (full && blk_ready) begin
          full <= 1'b0;
        end
      end
    end
  end

  // block payload
  always_ff @(posedge clk) begin
    if (capture) begin
      block_q <= in_block;
    end
  end

  assign blk_valid = full;
  assign blk_data  = block_q;

endmodule

`default_nettype wire

/* source/bc1_decoder_top.sv */
`timescale 1ns/1ns
`default_nettype none

module bc1_decoder_top
  import bc1_pkg::*;
(
  input  logic               clk,
  input  logic               rstn,
  input  logic               in_req,
  output logic               in_ack,
  input  logic [BLOCK_W-1:0] in_block,
  output logic               out_req,
  input  logic               out_ack,
  output logic [TEXEL_W-1:0] out_texel,
  output logic [IDX_W-1:0]   out_index,
  output logic               out_last
);

  // intake to palette stage
  logic                 blk_valid;
  logic                 blk_ready;
  logic [BLOCK_W-1:0]   blk_data;

  // palette stage to texel stream
  logic                 pal_valid;
  logic                 pal_ready;
  logic [4*TEXEL_W-1:0] pal_colors;
  logic [IDXS_W-1:0]    pal_indices;

  bc1_block_intake u_intake (
    .clk       (clk),
    .rstn      (rstn),
    .in_req    (in_req),
    .in_ack    (in_ack),
    .in_block  (in_block),
    .blk_valid (blk_valid),
    .blk_ready (blk_ready),
    .blk_data  (blk_data)
  );

  bc1_palette_gen u_palette (
    .clk         (clk),
    .rstn        (rstn),
    .blk_valid   (blk_valid),
    .blk_ready   (blk_ready),
    .blk_data    (blk_data),
    .pal_valid   (pal_valid),
    .pal_ready   (pal_ready),
    .pal_colors  (pal_colors),
    .pal_indices (pal_indices)
  );

  bc1_texel_stream u_stream (
    .clk         (clk),
    .rstn        (rstn),
    .pal_valid   (pal_valid),
    .pal_ready   (pal_ready),
    .pal_colors  (pal_colors),
    .pal_indices (pal_indices),
    .out_req     (out_req),
    .out_ack     (out_ack),
    .out_texel   (out_texel),
    .out_index   (out_index),
    .out_last    (out_last)
  );

endmodule

`default_nettype wire

/* source/bc1_palette_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module bc1_palette_gen
  import bc1_pkg::*;
(
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 blk_valid,
  output logic                 blk_ready,
  input  logic [BLOCK_W-1:0]   blk_data,
  output logic                 pal_valid,
  input  logic                 pal_ready,
  output logic [4*TEXEL_W-1:0] pal_colors,
  output logic [IDXS_W-1:0]    pal_indices
);

  bc1_color_u         c0;
  bc1_color_u         c1;
  logic [TEXEL_W-1:0] e0;
  logic [TEXEL_W-1:0] e1;
  logic [TEXEL_W-1:0] e2;
  logic [TEXEL_W-1:0] e3;
  logic               four_color;
  logic               take;

  // 565 to 888 by repeating the top bits into the low bits
  function automatic logic [TEXEL_W-1:0] expand565(input bc1_color_u c);
    return {c.f.r, c.f.r[4:2], c.f.g, c.f.g[5:4], c.f.b, c.f.b[4:2]};
  endfunction

  // (2a + b) / 3 per channel, truncating
  function automatic logic [TEXEL_W-1:0] third_mix(input logic [TEXEL_W-1:0] a,
                                                   input logic [TEXEL_W-1:0] b);
    logic [9:0]         sum;
    logic [TEXEL_W-1:0] res;
    for (int ch = 0; ch < 3; ch++) begin
      // 10 bits holds 3 * 255
      sum = {1'b0, a[8*ch +: 8], 1'b0} + {2'b00, b[8*ch +: 8]};
      res[8*ch +: 8] = 8'(sum / 10'd3);
    end
    return res;
  endfunction

  // (a + b) >> 1 per channel
  function automatic logic [TEXEL_W-1:0] half_mix(input logic [TEXEL_W-1:0] a,
                                                  input logic [TEXEL_W-1:0] b);
    logic [8:0]         sum;
    logic [TEXEL_W-1:0] res;
    for (int ch = 0; ch < 3; ch++) begin
      sum = {1'b0, a[8*ch +: 8]} + {1'b0, b[8*ch +: 8]};
      res[8*ch +: 8] = sum[8:1];
    end
    return res;
  endfunction

  assign c0 = blk_data[C0_LSB +: 16];
  assign c1 = blk_data[C1_LSB +: 16];

  // mode is an unsigned compare of the raw words
  assign four_color = c0.raw > c1.raw;

  assign e0 = expand565(c0);
  assign e1 = expand565(c1);
  assign e2 = four_color ? third_mix(e0, e1) : half_mix(e0, e1);
  // three-colour index 3 is plain black as there is no alpha
  assign e3 = four_color ? third_mix(e1, e0) : '0;

  // free slot, or the current palette leaves this cycle
  assign blk_ready = !pal_valid || pal_ready;
  assign take      = blk_valid && blk_ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pal_valid <= 1'b0;
    end else if (take) begin
      pal_valid <= 1'b1;
    end else if (pal_ready) begin
      pal_valid <= 1'b0;
    end
  end

  // entry 0 in the low bits
  always_ff @(posedge clk) begin
    if (take) begin
      pal_colors  <= {e3, e2, e1, e0};
      pal_indices <= blk_data[IDXS_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* source/bc1_pkg.sv */
`default_nettype none

package bc1_pkg;

  // compressed block and expanded texel widths
  localparam int BLOCK_W = 64;
  localparam int TEXEL_W = 24;

  // texels per 4x4 block and width of a texel number
  localparam int TEXELS = 16;
  localparam int IDX_W  = 4;

  // block layout: color0 63:48, color1 47:32, indices 31:0
  localparam int C0_LSB  = 48;
  localparam int C1_LSB  = 32;
  localparam int IDXS_W  = 32;

  // rgb565 fields of one endpoint word
  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } bc1_rgb565_t;

  // endpoint word seen two ways
  // raw for the mode compare, fields for expansion
  typedef union packed {
    logic [15:0] raw;
    bc1_rgb565_t f;
  } bc1_color_u;

endpackage

`default_nettype wire

/* source/bc1_texel_stream.sv */
`timescale 1ns/1ns
`default_nettype none

module bc1_texel_stream
  import bc1_pkg::*;
(
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 pal_valid,
  output logic                 pal_ready,
  input  logic [4*TEXEL_W-1:0] pal_colors,
  input  logic [IDXS_W-1:0]    pal_indices,
  output logic                 out_req,
  input  logic                 out_ack,
  output logic [TEXEL_W-1:0]   out_texel,
  output logic [IDX_W-1:0]     out_index,
  output logic                 out_last
);

  logic                 busy;
  logic [IDX_W-1:0]     cnt;
  logic [4*TEXEL_W-1:0] colors_q;
  logic [IDXS_W-1:0]    indices_q;
  logic [1:0]           sel;

  // one block held at a time
  assign pal_ready = !busy;

  // out_req doubles as the req phase bit
  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy    <= 1'b0;
      cnt     <= '0;
      out_req <= 1'b0;
    end else if (!busy) begin
      if (pal_valid) begin
        busy <= 1'b1;
        cnt  <= '0;
      end
    end else if (!out_req) begin
      // previous ack must be back at zero
      if (!out_ack) begin
        out_req <= 1'b1;
      end
    end else if (out_ack) begin
      out_req <= 1'b0;
      if (out_last) begin
        busy <= 1'b0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && pal_valid) begin
      colors_q  <= pal_colors;
      indices_q <= pal_indices;
    end
  end

  // 2-bit code of texel i sits at bits 2i+1:2i
  assign sel       = indices_q[2*cnt +: 2];
  assign out_texel = colors_q[TEXEL_W*sel +: TEXEL_W];
  assign out_index = cnt;
  assign out_last  = cnt == IDX_W'(TEXELS - 1);

endmodule

`default_nettype wire

/* verif/bc1_decoder_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module bc1_decoder_chk
  import bc1_pkg::*;
(
  input logic               clk,
  input logic               rstn,
  input logic               in_req,
  input logic               in_ack,
  input logic               out_req,
  input logic               out_ack,
  input logic [TEXEL_W-1:0] out_texel,
  input logic [IDX_W-1:0]   out_index,
  input logic               out_last
);

  int unsigned fail_count = 0;

  // req stays up until ack is seen
  a_req_hold: assert property (@(posedge clk) disable iff (!rstn)
    out_req && !out_ack |=> out_req)
    else begin
      fail_count++;
      $error("out_req fell before out_ack rose");
    end

  // texel payload frozen while waiting for ack
  a_data_stable: assert property (@(posedge clk) disable iff (!rstn)
    out_req && !out_ack |=> $stable(out_texel) && $stable(out_index) && $stable(out_last))
    else begin
      fail_count++;
      $error("texel outputs changed while out_req waited for out_ack");
    end

  // no ack without a request
  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
    !in_ack && !in_req |=> !in_ack)
    else begin
      fail_count++;
      $error("in_ack rose while in_req was low");
    end

  a_reset_idle: assert property (@(posedge clk)
    $rose(rstn) |-> !in_ack && !out_req)
    else begin
      fail_count++;
      $error("in_ack or out_req high in the cycle after reset");
    end

endmodule

bind bc1_decoder_top bc1_decoder_chk u_chk (
  .clk       (clk),
  .rstn      (rstn),
  .in_req    (in_req),
  .in_ack    (in_ack),
  .out_req   (out_req),
  .out_ack   (out_ack),
  .out_texel (out_texel),
  .out_index (out_index),
  .out_last  (out_last)
);

`default_nettype wire

/* verif/bc1_decoder_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module bc1_decoder_tb
  import bc1_pkg::*;
();

  localparam int N_TESTS    = 8;
  localparam int MAX_CYCLES = N_TESTS * TEXELS * 14 + 200;

  logic               clk;
  logic               rstn;
  logic               in_req;
  logic               in_ack;
  logic [BLOCK_W-1:0] in_block;
  logic               out_req;
  logic               out_ack;
  logic [TEXEL_W-1:0] out_texel;
  logic [IDX_W-1:0]   out_index;
  logic               out_last;

  // stimulus table with hand-computed palettes
  string                test_name [N_TESTS];
  bc1_color_u           test_c0   [N_TESTS];
  bc1_color_u           test_c1   [N_TESTS];
  logic [IDXS_W-1:0]    test_idx  [N_TESTS];
  logic [TEXEL_W-1:0]   test_pal  [N_TESTS][4];

  int cycle_cnt = 0;

  bc1_decoder_top u_bc1_decoder_top (
    .clk       (clk),
    .rstn      (rstn),
    .in_req    (in_req),
    .in_ack    (in_ack),
    .in_block  (in_block),
    .out_req   (out_req),
    .out_ack   (out_ack),
    .out_texel (out_texel),
    .out_index (out_index),
    .out_last  (out_last)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: texels still missing after %0d cycles", MAX_CYCLES);
      $display("Test FAILED");
      $fatal(1, "run stopped on timeout");
    end else if (u_bc1_decoder_top.u_chk.fail_count != 0) begin
      $display("handshake checker reported an assertion failure");
      $display("Test FAILED");
      $fatal(1, "handshake assertion failed");
    end
  end

  task automatic set_row(input int i, input string name, input logic [15:0] c0,
                         input logic [15:0] c1, input logic [IDXS_W-1:0] idx,
                         input logic [TEXEL_W-1:0] e0, input logic [TEXEL_W-1:0] e1,
                         input logic [TEXEL_W-1:0] e2, input logic [TEXEL_W-1:0] e3);
    test_name[i]   = name;
    test_c0[i].raw = c0;
    test_c1[i].raw = c1;
    test_idx[i]    = idx;
    test_pal[i][0] = e0;
    test_pal[i][1] = e1;
    test_pal[i][2] = e2;
    test_pal[i][3] = e3;
  endtask

  task automatic load_table();
    // four-colour rows, c0 > c1
    set_row(0, "four_red_blue", 16'hF800, 16'h001F, 32'hE4E4_E4E4,
            24'hFF0000, 24'h0000FF, 24'hAA0055, 24'h5500AA);
    set_row(1, "four_white_black", 16'hFFFF, 16'h0000, 32'h1B1B_1B1B,
            24'hFFFFFF, 24'h000000, 24'hAAAAAA, 24'h555555);
    set_row(2, "four_white_magenta", 16'hFFFF, 16'hF81F, 32'hFFFF_FFFF,
            24'hFFFFFF, 24'hFF00FF, 24'hFFAAFF, 24'hFF55FF);
    set_row(3, "four_gray", 16'h8410, 16'h4208, 32'h0000_0000,
            24'h848284, 24'h424142, 24'h6E6C6E, 24'h585658);
    // three-colour rows, c0 <= c1
    set_row(4, "three_blue_red", 16'h001F, 16'hF800, 32'hE4E4_E4E4,
            24'h0000FF, 24'hFF0000, 24'h7F007F, 24'h000000);
    set_row(5, "three_equal", 16'h8410, 16'h8410, 32'hC3A5_5A3C,
            24'h848284, 24'h848284, 24'h848284, 24'h000000);
    set_row(6, "three_black_white", 16'h0000, 16'hFFFF, 32'h9C6B_27D8,
            24'h000000, 24'hFFFFFF, 24'h7F7F7F, 24'h000000);
    set_row(7, "four_green", 16'h07E0, 16'h0020, 32'h5555_AAAA,
            24'h00FF00, 24'h000400, 24'h00AB00, 24'h005700);
  endtask

  task automatic show_fail(input string name, input string what, input int t,
                           input logic [31:0] exp_v, input logic [31:0] act_v);
    $display("[FAIL] %s texel %0d %s expected %h actual %h", name, t, what, exp_v, act_v);
    $display("Test FAILED");
  endtask

  task automatic send_block(input int i);
    @(posedge clk);
    in_block <= {test_c0[i].raw, test_c1[i].raw, test_idx[i]};
    in_req   <= 1'b1;
    do @(negedge clk); while (!in_ack);
    @(posedge clk);
    in_req <= 1'b0;
    // ack back to zero closes the handshake
    do @(negedge clk); while (in_ack);
  endtask

  task automatic receive_block(input int i);
    logic [1:0]         sel;
    logic [TEXEL_W-1:0] exp_texel;
    int                 delay;
    for (int t = 0; t < TEXELS; t++) begin
      do @(negedge clk); while (!out_req);
      // code of texel t picks the palette entry
      sel       = test_idx[i][2*t +: 2];
      exp_texel = test_pal[i][sel];
      assert (out_index == IDX_W'(t)) else begin
        show_fail(test_name[i], "out_index", t, 32'(t), 32'(out_index));
        $fatal(1, "texel number mismatch");
      end
      assert (out_last == (t == TEXELS - 1)) else begin
        show_fail(test_name[i], "out_last", t, 32'(t == TEXELS - 1), 32'(out_last));
        $fatal(1, "last flag mismatch");
      end
      assert (out_texel == exp_texel) else begin
        show_fail(test_name[i], "out_texel", t, 32'(exp_texel), 32'(out_texel));
        $fatal(1, "texel colour mismatch");
      end
      delay = $urandom % 6;
      repeat (delay) @(posedge clk);
      @(posedge clk);
      out_ack <= 1'b1;
      do @(negedge clk); while (out_req);
      @(posedge clk);
      out_ack <= 1'b0;
    end
  endtask

  initial begin
    void'($urandom(32'h8011_bbae));
    rstn     = 1'b0;
    in_req   = 1'b0;
    in_block = '0;
    out_ack  = 1'b0;
    load_table();
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    // idle after reset while nothing is sent yet
    repeat (3) begin
      @(negedge clk);
      assert (!in_ack && !out_req) else begin
        $display("in_ack or out_req went high after reset before any block was sent");
        $display("Test FAILED");
        $fatal(1, "bad idle state");
      end
    end
    fork
      begin
        for (int i = 0; i < N_TESTS; i++) begin
          send_block(i);
        end
      end
      begin
        for (int i = 0; i < N_TESTS; i++) begin
          receive_block(i);
        end
      end
    join
    // no stray texel after the last block
    repeat (10) begin
      @(negedge clk);
      assert (!out_req) else begin
        $display("out_req went high again after the last block");
        $display("Test FAILED");
        $fatal(1, "extra texel");
      end
    end
    if (u_bc1_decoder_top.u_chk.fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("handshake checker saw %0d assertion failures",
               u_bc1_decoder_top.u_chk.fail_count);
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
source/bc1_pkg.sv
source/bc1_block_intake.sv
source/bc1_palette_gen.sv
source/bc1_texel_stream.sv
source/bc1_decoder_top.sv
verif/bc1_decoder_chk.sv
verif/bc1_decoder_tb.sv
